/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module decodeStageTb -Mdir obj_dir
	@out="$$(./obj_dir/VdecodeStageTb)"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* hw/controlUnit.sv */
`default_nettype none

module controlUnit
    import decodePkg::*;
(
    input  instrWord_u  instr,
    output ctrlBundle_t ctrl
);

    localparam logic [6:0] opR     = 7'b0110011;
    localparam logic [6:0] opIArith = 7'b0010011;
    localparam logic [6:0] opLoad  = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal   = 7'b1101111;
    localparam logic [6:0] opJalr  = 7'b1100111;
    localparam logic [6:0] opLui   = 7'b0110111;
    localparam logic [6:0] opAuipc = 7'b0010111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       bit30;

    assign opcode = instr.rType.opcode;
    assign funct3 = instr.rType.funct3;
    assign bit30  = instr.rType.funct7[5];     // sub / sra select

    always_comb begin
        ctrl = '0;                              // unknown opcode leaves all zero
        case (opcode)
            opR, opIArith: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = (opcode == opIArith);
                ctrl.immSrc   = immSelI;
                case (funct3)
                    3'd0: begin
                        // no subi, so bit 30 only matters for R type
                        if (opcode == opR && bit30) ctrl.aluControl = 4'd1;
                        else                        ctrl.aluControl = 4'd0;
                    end
                    3'd1: ctrl.aluControl = 4'd5;          // sll
                    3'd2: ctrl.aluControl = 4'd8;          // slt
                    3'd3: ctrl.aluControl = 4'd9;          // sltu
                    3'd4: ctrl.aluControl = 4'd4;          // xor
                    3'd5: ctrl.aluControl = bit30 ? 4'd7 : 4'd6;   // sra / srl
                    3'd6: ctrl.aluControl = 4'd3;          // or
                    3'd7: ctrl.aluControl = 4'd2;          // and
                    default: ctrl.aluControl = 4'd0;
                endcase
            end

            opLoad: begin
                ctrl.regWrite   = 1'b1;
                ctrl.resultSrc  = 2'd1;                // data from memory
                ctrl.aluControl = 4'd0;                // address = rs1 + imm
                ctrl.aluSrc     = 1'b1;
                ctrl.immSrc     = immSelI;
                case (funct3)
                    3'd0: ctrl.memoryOp = 3'd0;        // lb
                    3'd1: ctrl.memoryOp = 3'd1;        // lh
                    3'd2: ctrl.memoryOp = 3'd2;        // lw
                    3'd4: ctrl.memoryOp = 3'd3;        // lbu
                    3'd5: ctrl.memoryOp = 3'd4;        // lhu
                    default: ctrl.memoryOp = 3'd0;
                endcase
            end

            opStore: begin
                ctrl.memWrite   = 1'b1;
                ctrl.aluControl = 4'd0;
                ctrl.aluSrc     = 1'b1;
                ctrl.immSrc     = immSelS;
                case (funct3)
                    3'd0: ctrl.memoryOp = 3'd0;        // sb
                    3'd1: ctrl.memoryOp = 3'd1;        // sh
                    3'd2: ctrl.memoryOp = 3'd2;        // sw
                    default: ctrl.memoryOp = 3'd0;
                endcase
            end

            opBranch: begin
                ctrl.aluControl = 4'd1;                // compare by subtraction
                ctrl.immSrc     = immSelB;
                case (funct3)
                    3'd0: ctrl.branch = 3'd1;          // beq
                    3'd1: ctrl.branch = 3'd2;          // bne
                    3'd4: ctrl.branch = 3'd3;          // blt
                    3'd5: ctrl.branch = 3'd4;          // bge
                    3'd6: ctrl.branch = 3'd5;          // bltu
                    3'd7: ctrl.branch = 3'd6;          // bgeu
                    default: ctrl.branch = 3'd0;
                endcase
            end

            opJal: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = 2'd2;                 // link value pc+4
                ctrl.jump      = 2'd1;
                ctrl.immSrc    = immSelJ;
            end

            opJalr: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = 2'd2;
                ctrl.jump      = 2'd2;
                ctrl.immSrc    = immSelI;              // target is rs1 + imm
            end

            opLui, opAuipc: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.upperOp  = (opcode == opLui) ? 2'd1 : 2'd2;   // 0 or pc into A
                ctrl.immSrc   = immSelU;
            end

            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/decodeExecReg.sv */
`default_nettype none

`include "decode_defines.svh"

module decodeExecReg
    import decodePkg::*;
(
    input  logic             clk,
    input  logic             arstN,
    input  logic             stall,
    input  logic             flush,
    input  fetchSlot_t       decodeSlot,
    input  ctrlBundle_t      ctrl,
    input  logic [`XLEN-1:0] imm,
    input  logic [`XLEN-1:0] rd1,
    input  logic [`XLEN-1:0] rd2,
    output execSlot_t        execOut
);

    execSlot_t nextSlot;

    always_comb begin
        nextSlot.ctrl   = decodeSlot.valid ? ctrl : ctrlBundle_t'('0);  // idle slot stays inert
        nextSlot.rd1    = rd1;
        nextSlot.rd2    = rd2;
        nextSlot.imm    = imm;
        nextSlot.pc     = decodeSlot.pc;
        nextSlot.rdAddr = decodeSlot.instr.rType.rd;
        nextSlot.valid  = decodeSlot.valid;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            execOut <= '0;
        end else if (flush) begin
            execOut.valid <= 1'b0;                  // bubble, beats stall
            execOut.ctrl  <= '0;
        end else if (!stall) begin
            execOut <= nextSlot;
        end
    end

    // a bubble reaching execute must not write anything
    bubbleInert: assert property (
        @(posedge clk) disable iff (!arstN)
        !execOut.valid |-> (!execOut.ctrl.regWrite && !execOut.ctrl.memWrite)
    ) else $error("invalid exec slot carries a write enable");

endmodule

`default_nettype wire

/* hw/decodePkg.sv */
`default_nettype none

`include "decode_defines.svh"

package decodePkg;

    // immediate format select, shared by control unit and extender
    localparam logic [2:0] immSelI = 3'd0;
    localparam logic [2:0] immSelS = 3'd1;
    localparam logic [2:0] immSelB = 3'd2;
    localparam logic [2:0] immSelU = 3'd3;
    localparam logic [2:0] immSelJ = 3'd4;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } iType_t;

    typedef struct packed {
        logic [6:0]             imm11to5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm4to0;
        logic [6:0]             opcode;
    } sType_t;

    typedef struct packed {
        logic                   imm12;
        logic [5:0]             imm10to5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm4to1;
        logic                   imm11;
        logic [6:0]             opcode;
    } bType_t;

    typedef struct packed {
        logic [19:0]            imm;        // bits 31:12 of the result
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } uType_t;

    typedef struct packed {
        logic                   imm20;
        logic [9:0]             imm10to1;
        logic                   imm11;
        logic [7:0]             imm19to12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } jType_t;

    // one instruction word, six ways to read it
    typedef union packed {
        rType_t rType;
        iType_t iType;
        sType_t sType;
        bType_t bType;
        uType_t uType;
        jType_t jType;
    } instrWord_u;

    typedef struct packed {
        logic       regWrite;
        logic [1:0] resultSrc;      // 0 alu, 1 mem, 2 pc+4
        logic       memWrite;
        logic [1:0] jump;           // 1 jal, 2 jalr
        logic [2:0] branch;         // 1..6 beq bne blt bge bltu bgeu
        logic [3:0] aluControl;
        logic       aluSrc;         // 1 selects immediate
        logic [1:0] upperOp;        // 1 zero into A, 2 pc into A
        logic [2:0] memoryOp;       // b, h, w, bu, hu
        logic [2:0] immSrc;
    } ctrlBundle_t;

    typedef struct packed {
        instrWord_u        instr;
        logic [`XLEN-1:0]  pc;
        logic              valid;
    } fetchSlot_t;

    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } wbPort_t;

    typedef struct packed {
        ctrlBundle_t            ctrl;
        logic [`XLEN-1:0]       rd1;
        logic [`XLEN-1:0]       rd2;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rdAddr;
        logic                   valid;
    } execSlot_t;

endpackage

`default_nettype wire

/* hw/decodeStage.sv */
`default_nettype none

`include "decode_defines.svh"

module decodeStage
    import decodePkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  logic       stall,
    input  logic       flush,
    input  fetchSlot_t fetchIn,
    input  wbPort_t    wbIn,
    output execSlot_t  execOut
);

    fetchSlot_t       decodeSlot;
    ctrlBundle_t      ctrl;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rd1;
    logic [`XLEN-1:0] rd2;

    fetchDecodeReg uFetchDecodeReg (
        .clk        (clk),
        .arstN      (arstN),
        .stall      (stall),
        .fetchIn    (fetchIn),
        .decodeSlot (decodeSlot)
    );

    controlUnit uControlUnit (
        .instr (decodeSlot.instr),
        .ctrl  (ctrl)
    );

    immExtend uImmExtend (
        .instr  (decodeSlot.instr),
        .immSrc (ctrl.immSrc),
        .imm    (imm)
    );

    regFile uRegFile (
        .clk   (clk),
        .arstN (arstN),
        .rs1   (decodeSlot.instr.rType.rs1),
        .rs2   (decodeSlot.instr.rType.rs2),
        .wbIn  (wbIn),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    decodeExecReg uDecodeExecReg (
        .clk        (clk),
        .arstN      (arstN),
        .stall      (stall),
        .flush      (flush),
        .decodeSlot (decodeSlot),
        .ctrl       (ctrl),
        .imm        (imm),
        .rd1        (rd1),
        .rd2        (rd2),
        .execOut    (execOut)
    );

endmodule

`default_nettype wire

/* hw/fetchDecodeReg.sv */
`default_nettype none

module fetchDecodeReg
    import decodePkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  logic       stall,
    input  fetchSlot_t fetchIn,
    output fetchSlot_t decodeSlot
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decodeSlot <= '0;
        end else if (!stall) begin
            decodeSlot <= fetchIn;      // strobe dropped while stalled
        end
    end

    // fetch strobe must be a clean level once out of reset
    validKnown: assert property (
        @(posedge clk) disable iff (!arstN) !$isunknown(fetchIn.valid)
    ) else $error("fetchIn.valid is X");

endmodule

`default_nettype wire

/* hw/immExtend.sv */
`default_nettype none

`include "decode_defines.svh"

module immExtend
    import decodePkg::*;
(
    input  instrWord_u       instr,
    input  logic [2:0]       immSrc,
    output logic [`XLEN-1:0] imm
);

    always_comb begin
        case (immSrc)
            immSelI: imm = {{20{instr.iType.imm[11]}}, instr.iType.imm};
            immSelS: imm = {{20{instr.sType.imm11to5[6]}},
                            instr.sType.imm11to5, instr.sType.imm4to0};
            immSelB: imm = {{19{instr.bType.imm12}}, instr.bType.imm12,
                            instr.bType.imm11, instr.bType.imm10to5,
                            instr.bType.imm4to1, 1'b0};        // halfword aligned
            immSelU: imm = {instr.uType.imm, 12'b0};
            immSelJ: imm = {{11{instr.jType.imm20}}, instr.jType.imm20,
                            instr.jType.imm19to12, instr.jType.imm11,
                            instr.jType.imm10to1, 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/regFile.sv */
`default_nettype none

`include "decode_defines.svh"

module regFile
    import decodePkg::*;
(
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    input  wbPort_t                wbIn,
    output logic [`XLEN-1:0]       rd1,
    output logic [`XLEN-1:0]       rd2
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbIn.en && wbIn.addr != '0) begin
            regs[wbIn.addr] <= wbIn.data;           // x0 never written
        end
    end

    // no bypass, same-cycle write shows up next cycle
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

    wbAddrKnown: assert property (
        @(posedge clk) disable iff (!arstN) wbIn.en |-> !$isunknown(wbIn.addr)
    ) else $error("writeback address is X while en is set");

endmodule

`default_nettype wire

/* include/decode_defines.svh */
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// datapath and pc width
`define XLEN 32

// register file geometry
`define REG_COUNT 32
`define REG_ADDR_W 5

`endif

/* src.f */
+incdir+include
hw/decodePkg.sv
hw/fetchDecodeReg.sv
hw/controlUnit.sv
hw/immExtend.sv
hw/regFile.sv
hw/decodeExecReg.sv
hw/decodeStage.sv
verif/decodeStageTb.sv

/* verif/decodeStageTb.sv */
`default_nettype none

`include "decode_defines.svh"

module decodeStageTb
    import decodePkg::*;
();

    logic       clk;
    logic       arstN;
    logic       stall;
    logic       flush;
    fetchSlot_t fetchIn;
    wbPort_t    wbIn;
    execSlot_t  execOut;

    integer           seed;
    int               errors;
    int               passCount;
    int               failCount;
    int               errStart;
    int               i;
    string            curTest;
    logic [`XLEN-1:0] pcNext;
    logic [`XLEN-1:0] shadow [`REG_COUNT];      // mirror of the register file
    execSlot_t        expQ[$];                  // slots still in flight
    execSlot_t        heldOut;
    execSlot_t        expSlot;
    logic             edgeStall;                // levels seen by the DUT at the last edge
    logic             edgeFlush;

    // decode tables indexed by funct3
    logic [3:0] aluByF3 [8] = '{4'd0, 4'd5, 4'd8, 4'd9, 4'd4, 4'd6, 4'd3, 4'd2};
    logic [2:0] loadOpByF3 [8] = '{3'd0, 3'd1, 3'd2, 3'd0, 3'd3, 3'd4, 3'd0, 3'd0};
    logic [2:0] branchByF3 [8] = '{3'd1, 3'd2, 3'd0, 3'd0, 3'd3, 3'd4, 3'd5, 3'd6};

    decodeStage u_dut (
        .clk     (clk),
        .arstN   (arstN),
        .stall   (stall),
        .flush   (flush),
        .fetchIn (fetchIn),
        .wbIn    (wbIn),
        .execOut (execOut)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic isLegalOp(input logic [6:0] op);
        return op inside {7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011, 7'b1100011,
                          7'b1101111, 7'b1100111, 7'b0110111, 7'b0010111};
    endfunction

    function automatic ctrlBundle_t refCtrl(input logic [31:0] w);
        ctrlBundle_t c;
        logic [2:0]  f3;
        logic        bumpAlu;
        c = '0;
        f3 = w[14:12];
        // bit 30 turns add into sub (R only) and srl into sra
        bumpAlu = w[30] && (f3 == 3'd5 || (f3 == 3'd0 && w[5]));
        case (w[6:0])
            7'b0110011, 7'b0010011: begin
                c.regWrite   = 1'b1;
                c.aluSrc     = !w[5];                   // immediate form
                c.aluControl = aluByF3[f3] + (bumpAlu ? 4'd1 : 4'd0);
            end
            7'b0000011: begin
                c.regWrite  = 1'b1;
                c.resultSrc = 2'd1;
                c.aluSrc    = 1'b1;
                c.memoryOp  = loadOpByF3[f3];
            end
            7'b0100011: begin
                c.memWrite = 1'b1;
                c.aluSrc   = 1'b1;
                c.memoryOp = (f3 < 3'd3) ? f3 : 3'd0;
                c.immSrc   = 3'd1;
            end
            7'b1100011: begin
                c.aluControl = 4'd1;
                c.branch     = branchByF3[f3];
                c.immSrc     = 3'd2;
            end
            7'b1101111: begin
                c.regWrite  = 1'b1;
                c.resultSrc = 2'd2;
                c.jump      = 2'd1;
                c.immSrc    = 3'd4;
            end
            7'b1100111: begin
                c.regWrite  = 1'b1;
                c.resultSrc = 2'd2;
                c.jump      = 2'd2;
            end
            7'b0110111, 7'b0010111: begin
                c.regWrite = 1'b1;
                c.aluSrc   = 1'b1;
                c.upperOp  = w[5] ? 2'd1 : 2'd2;        // lui has bit 5 set
                c.immSrc   = 3'd3;
            end
            default: c = '0;
        endcase
        return c;
    endfunction

    function automatic logic [31:0] refImm(input logic [31:0] w, input logic [2:0] sel);
        case (sel)
            3'd0: return {{20{w[31]}}, w[31:20]};
            3'd1: return {{20{w[31]}}, w[31:25], w[11:7]};
            3'd2: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            3'd3: return {w[31:12], 12'h000};
            3'd4: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default: return '0;
        endcase
    endfunction

    // kinds 0..8 are R, I-arith, load, store, branch, jal, jalr, lui, auipc; 9 is junk
    function automatic logic [31:0] makeInstr(input int kind);
        logic [31:0] w;
        logic [2:0]  pick;
        w = $random(seed);
        pick = w[14:12];
        case (kind)
            0: begin
                w[6:0]   = 7'b0110011;
                w[31:25] = {1'b0, w[30], 5'b0};
            end
            1: w[6:0] = 7'b0010011;
            2: begin
                w[6:0] = 7'b0000011;
                if (pick == 3'd3 || pick == 3'd6 || pick == 3'd7) w[14:12] = 3'd2;
            end
            3: begin
                w[6:0]   = 7'b0100011;
                w[14:12] = 3'(pick % 3);
            end
            4: begin
                w[6:0] = 7'b1100011;
                if (pick == 3'd2 || pick == 3'd3) w[13] = 1'b0;
            end
            5: w[6:0] = 7'b1101111;
            6: begin
                w[6:0]   = 7'b1100111;
                w[14:12] = 3'd0;
            end
            7: w[6:0] = 7'b0110111;
            8: w[6:0] = 7'b0010111;
            default: if (isLegalOp(w[6:0])) w[0] = ~w[0];  // legal opcodes all end in 1
        endcase
        return w;
    endfunction

    task automatic present(input logic [31:0] w, input bit expectIt);
        execSlot_t e;
        fetchIn.instr <= instrWord_u'(w);
        fetchIn.pc    <= pcNext;
        fetchIn.valid <= 1'b1;
        if (expectIt) begin
            e.ctrl   = refCtrl(w);
            e.rd1    = shadow[w[19:15]];
            e.rd2    = shadow[w[24:20]];
            e.imm    = refImm(w, e.ctrl.immSrc);
            e.pc     = pcNext;
            e.rdAddr = w[11:7];
            e.valid  = 1'b1;
            expQ.push_back(e);
        end
        pcNext = pcNext + 32'd4;
    endtask

    task automatic idle();
        @(posedge clk);
        fetchIn.valid <= 1'b0;
        stall         <= 1'b0;
        flush         <= 1'b0;
    endtask

    task automatic drainQueue();
        int n;
        for (n = 0; n < 20 && expQ.size() != 0; n++) begin
            @(posedge clk);
        end
        if (expQ.size() != 0) begin
            $display("%s: timeout, %0d expected slots never reached execute",
                     curTest, expQ.size());
            errors++;
            expQ.delete();
        end
    endtask

    task automatic runStream(input int kLo, input int kHi, input int count, input bit withStall);
        int sent;
        int len;
        sent = 0;
        while (sent < count) begin
            @(posedge clk);
            if (withStall && ({$random(seed)} % 4) == 0) begin
                len = 1 + {$random(seed)} % 4;
                stall         <= 1'b1;
                fetchIn.valid <= 1'b0;            // nothing offered while held
                repeat (len - 1) @(posedge clk);
            end else begin
                stall <= 1'b0;
                present(makeInstr(kLo + {$random(seed)} % (kHi - kLo + 1)), 1'b1);
                sent++;
            end
        end
        idle();
        drainQueue();
    endtask

    task automatic writeReg(input logic [4:0] a, input logic [31:0] d);
        @(posedge clk);
        wbIn.en   <= 1'b1;
        wbIn.addr <= a;
        wbIn.data <= d;
        if (a != 5'd0) shadow[a] = d;
        @(posedge clk);
        wbIn.en <= 1'b0;
    endtask

    task automatic finishTest(input int errBefore);
        if (errors == errBefore) begin
            $display("test %s: PASS", curTest);
            passCount++;
        end else begin
            $display("test %s: FAIL", curTest);
            failCount++;
        end
    endtask

    always @(negedge clk) begin
        if (!arstN) begin
            edgeStall = 1'b0;
            edgeFlush = 1'b0;
        end else begin
            if (edgeFlush) begin
                if (execOut.valid || execOut.ctrl != '0) begin
                    $display("CHECK FAILED %s expected %h actual %h", curTest,
                             {ctrlBundle_t'(0), 1'b0}, {execOut.ctrl, execOut.valid});
                    errors++;
                end
            end else if (edgeStall) begin
                if (execOut !== heldOut) begin
                    $display("CHECK FAILED %s expected %h actual %h", curTest, heldOut, execOut);
                    errors++;
                end
            end else if (execOut.valid) begin
                if (expQ.size() == 0) begin
                    $display("%s: valid slot in execute with none expected", curTest);
                    errors++;
                end else begin
                    expSlot = expQ.pop_front();
                    if (execOut !== expSlot) begin
                        $display("CHECK FAILED %s expected %h actual %h",
                                 curTest, expSlot, execOut);
                        errors++;
                    end
                end
            end else if (execOut.ctrl != '0) begin
                $display("CHECK FAILED %s expected %h actual %h", curTest,
                         ctrlBundle_t'(0), execOut.ctrl);
                errors++;
            end
            heldOut   = execOut;
            edgeStall = stall;
            edgeFlush = flush;
        end
    end

    initial begin
        seed      = 17968;
        errors    = 0;
        passCount = 0;
        failCount = 0;
        pcNext    = 32'h0000_1000;
        curTest   = "reset";
        arstN     = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        fetchIn   = '0;
        wbIn      = '0;
        for (i = 0; i < `REG_COUNT; i++) shadow[i] = '0;
        repeat (5) @(posedge clk);
        arstN <= 1'b1;

        curTest = "reset_idle";
        errStart = errors;
        repeat (6) begin
            @(negedge clk);
            if (execOut.valid || execOut.ctrl != '0) begin
                $display("CHECK FAILED %s expected %h actual %h", curTest,
                         {ctrlBundle_t'(0), 1'b0}, {execOut.ctrl, execOut.valid});
                errors++;
            end
        end
        finishTest(errStart);

        curTest = "alu_ops";
        errStart = errors;
        runStream(0, 1, 24, 1'b0);
        finishTest(errStart);

        curTest = "mem_branch_jump_upper";
        errStart = errors;
        runStream(2, 8, 40, 1'b0);
        finishTest(errStart);

        curTest = "regfile_reads";
        errStart = errors;
        for (i = 0; i < 16; i++) writeReg(5'($random(seed)), $random(seed));
        writeReg(5'd0, $random(seed));            // must be dropped
        runStream(0, 0, 16, 1'b0);
        @(posedge clk);
        present(32'h0000_0033, 1'b1);              // add x0, x0, x0
        idle();
        drainQueue();
        finishTest(errStart);

        curTest = "stall_flush";
        errStart = errors;
        runStream(0, 9, 24, 1'b1);
        @(posedge clk);
        present(makeInstr(0), 1'b1);
        @(posedge clk);
        present(makeInstr(1), 1'b0);               // dropped by the flush
        @(posedge clk);
        fetchIn.valid <= 1'b0;
        flush         <= 1'b1;
        idle();
        runStream(2, 8, 6, 1'b0);
        @(posedge clk);
        present(makeInstr(3), 1'b1);
        @(posedge clk);
        present(makeInstr(4), 1'b1);               // still in decode when the flush lands
        @(posedge clk);
        fetchIn.valid <= 1'b0;
        flush         <= 1'b1;                     // execute empties while decode keeps its word
        stall         <= 1'b1;
        idle();
        drainQueue();
        finishTest(errStart);

        curTest = "junk_opcodes";
        errStart = errors;
        runStream(9, 9, 12, 1'b0);
        finishTest(errStart);

        $display("tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0 && errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
